//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = move_gen_tb
FILELIST  = move_gen.f
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- logic/move_gen.sv
`timescale 1ns/1ps

module move_gen
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     board_valid,
   input  vchess_pkg::board_t       board,
   input  logic                     white_to_move,
   input  vchess_pkg::castle_t      castle_mask,
   input  vchess_pkg::ep_t          en_passant_col, // Cleared in every successor
   input  vchess_pkg::move_index_t  move_index,
   input  logic                     clear_moves,
   output logic                     moves_ready,
   output vchess_pkg::move_count_t  move_count,
   output logic                     overflow,
   output vchess_pkg::board_t       board_out,
   output logic                     white_to_move_out,
   output vchess_pkg::castle_t      castle_mask_out,
   output vchess_pkg::ep_t          en_passant_col_out
);
   import vchess_pkg::*;

   logic    start;
   board_t  board_q;
   logic    white_q;
   castle_t castle_q;
   logic    ray_start;
   square_t from_sq;
   dir_t    ray_dir;
   logic    ray_done;
   logic    move_valid;
   square_t move_from;   // Origin of the emitted target
   square_t to_sq;

   square_scan scan0
   (
      .clk           (clk),
      .reset         (reset),
      .board_valid   (board_valid),
      .board         (board),
      .white_to_move (white_to_move),
      .castle_mask   (castle_mask),
      .clear_moves   (clear_moves),
      .ray_done      (ray_done),
      .start         (start),
      .board_q       (board_q),
      .white_q       (white_q),
      .castle_q      (castle_q),
      .ray_start     (ray_start),
      .from_sq       (from_sq),
      .ray_dir       (ray_dir),
      .moves_ready   (moves_ready)
   );

   ray_walker walk0
   (
      .clk         (clk),
      .reset       (reset),
      .ray_start   (ray_start),
      .from_sq     (from_sq),
      .ray_dir     (ray_dir),
      .board_q     (board_q),
      .white_q     (white_q),
      .ray_done    (ray_done),
      .move_valid  (move_valid),
      .from_sq_out (move_from),
      .to_sq       (to_sq)
   );

   move_store store0
   (
      .clk                (clk),
      .reset              (reset),
      .start              (start),
      .board_q            (board_q),
      .white_q            (white_q),
      .castle_q           (castle_q),
      .move_valid         (move_valid),
      .from_sq            (move_from),
      .to_sq              (to_sq),
      .move_index         (move_index),
      .move_count         (move_count),
      .overflow           (overflow),
      .board_out          (board_out),
      .white_to_move_out  (white_to_move_out),
      .castle_mask_out    (castle_mask_out),
      .en_passant_col_out (en_passant_col_out)
   );

endmodule

//--- logic/move_store.sv
`timescale 1ns/1ps

module move_store
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     start,
   input  vchess_pkg::board_t       board_q,
   input  logic                     white_q,
   input  vchess_pkg::castle_t      castle_q,
   input  logic                     move_valid,
   input  vchess_pkg::square_t      from_sq,
   input  vchess_pkg::square_t      to_sq,
   input  vchess_pkg::move_index_t  move_index,
   output vchess_pkg::move_count_t  move_count,
   output logic                     overflow,
   output vchess_pkg::board_t       board_out,
   output logic                     white_to_move_out,
   output vchess_pkg::castle_t      castle_mask_out,
   output vchess_pkg::ep_t          en_passant_col_out
);
   import vchess_pkg::*;

   logic [RAM_BITS-1:0] move_ram [MAX_POSITIONS];
   logic [RAM_BITS-1:0] rd_data;
   move_count_t         count;
   logic                full;
   piece_t              moved;
   board_t              succ_board;
   castle_t             succ_castle;

   assign full = (count == move_count_t'(MAX_POSITIONS));

   // Successor position for the current move
   always_comb
   begin
      moved      = board_q[int'(from_sq) * PIECE_BITS +: PIECE_BITS];
      succ_board = board_q;
      succ_board[int'(from_sq) * PIECE_BITS +: PIECE_BITS] = EMPTY_POSN;
      succ_board[int'(to_sq) * PIECE_BITS +: PIECE_BITS]   = moved;

      succ_castle = castle_q;
      if (from_sq == ROOK_HOME_WK || to_sq == ROOK_HOME_WK)
         succ_castle[CASTLE_WK] = 1'b0;
      if (from_sq == ROOK_HOME_WQ || to_sq == ROOK_HOME_WQ)
         succ_castle[CASTLE_WQ] = 1'b0;
      if (from_sq == ROOK_HOME_BK || to_sq == ROOK_HOME_BK)
         succ_castle[CASTLE_BK] = 1'b0;
      if (from_sq == ROOK_HOME_BQ || to_sq == ROOK_HOME_BQ)
         succ_castle[CASTLE_BQ] = 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count    <= '0;
         overflow <= 1'b0;
      end
      else if (start)
      begin
         count    <= '0;
         overflow <= 1'b0;
      end
      else if (move_valid)
      begin
         if (full)
            overflow <= 1'b1; // Move dropped
         else
            count <= count + 8'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (move_valid && !full && !start)
         move_ram[count[6:0]] <= {EP_NONE, succ_castle, ~white_q, succ_board};
   end

   // Registered read port
   always_ff @(posedge clk)
   begin
      rd_data <= move_ram[move_index];
   end

   assign move_count = count;
   assign {en_passant_col_out, castle_mask_out, white_to_move_out, board_out} = rd_data;

endmodule

//--- logic/ray_walker.sv
`timescale 1ns/1ps

module ray_walker
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 ray_start,
   input  vchess_pkg::square_t  from_sq,
   input  vchess_pkg::dir_t     ray_dir,
   input  vchess_pkg::board_t   board_q,
   input  logic                 white_q,
   output logic                 ray_done,
   output logic                 move_valid,
   output vchess_pkg::square_t  from_sq_out,
   output vchess_pkg::square_t  to_sq
);
   import vchess_pkg::*;

   logic       busy;
   logic       hit;       // Capture emitted, ray ends next cycle
   logic [2:0] row;
   logic [2:0] col;
   dir_t       dir;
   logic [3:0] dr;        // Two's complement step
   logic [3:0] dc;
   logic [3:0] nr;
   logic [3:0] nc;
   logic       off_board;
   square_t    target;
   piece_t     target_piece;
   logic       target_empty;
   logic       target_own;
   logic       step;

   always_comb
   begin
      dr = 4'd0;
      dc = 4'd0;
      case (dir)
         DIR_N:  dr = 4'd1;
         DIR_E:  dc = 4'd1;
         DIR_S:  dr = 4'hf;
         DIR_W:  dc = 4'hf;
         DIR_NE:
         begin
            dr = 4'd1;
            dc = 4'd1;
         end
         DIR_SE:
         begin
            dr = 4'hf;
            dc = 4'd1;
         end
         DIR_SW:
         begin
            dr = 4'hf;
            dc = 4'hf;
         end
         default:
         begin
            dr = 4'd1;  // NW
            dc = 4'hf;
         end
      endcase
   end

   // Row 8 or row -1 both set bit 3
   assign nr           = {1'b0, row} + dr;
   assign nc           = {1'b0, col} + dc;
   assign off_board    = nr[3] | nc[3];
   assign target       = {nr[2:0], nc[2:0]};
   assign target_piece = board_q[int'(target) * PIECE_BITS +: PIECE_BITS];
   assign target_empty = (target_piece == EMPTY_POSN);
   assign target_own   = (target_piece[BLACK_BIT] == ~white_q);
   assign step         = busy && !hit && !off_board && (target_empty || !target_own);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy       <= 1'b0;
         hit        <= 1'b0;
         ray_done   <= 1'b0;
         move_valid <= 1'b0;
      end
      else
      begin
         ray_done   <= 1'b0;
         move_valid <= step;
         if (ray_start)
         begin
            busy <= 1'b1;
            hit  <= 1'b0;
         end
         else if (step)
            hit <= !target_empty;
         else if (busy)
         begin
            busy     <= 1'b0; // Edge, own piece or after a capture
            ray_done <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (ray_start)
      begin
         row         <= from_sq[5:3];
         col         <= from_sq[2:0];
         dir         <= ray_dir;
         from_sq_out <= from_sq;
      end
      else if (step)
      begin
         row   <= nr[2:0];
         col   <= nc[2:0];
         to_sq <= target;
      end
   end

endmodule

//--- logic/square_scan.sv
`timescale 1ns/1ps

module square_scan
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 board_valid,
   input  vchess_pkg::board_t   board,
   input  logic                 white_to_move,
   input  vchess_pkg::castle_t  castle_mask,
   input  logic                 clear_moves,
   input  logic                 ray_done,
   output logic                 start,
   output vchess_pkg::board_t   board_q,
   output logic                 white_q,
   output vchess_pkg::castle_t  castle_q,
   output logic                 ray_start,
   output vchess_pkg::square_t  from_sq,
   output vchess_pkg::dir_t     ray_dir,
   output logic                 moves_ready
);
   import vchess_pkg::*;

   typedef enum logic [2:0]
   {
      ST_IDLE,
      ST_LATCH,
      ST_SQUARE,
      ST_RAY,
      ST_WAIT_RAY,
      ST_DONE
   } state_t;

   state_t  state;
   square_t sq;
   dir_t    dir;
   dir_t    dir_last;
   piece_t  piece;
   logic    own_piece;
   logic    is_slider;
   dir_t    dir_first;
   dir_t    dir_final;

   assign piece     = board_q[int'(sq) * PIECE_BITS +: PIECE_BITS];
   assign own_piece = (piece != EMPTY_POSN) && (piece[BLACK_BIT] == ~white_q);

   // Direction range per slider type
   always_comb
   begin
      is_slider = 1'b1;
      dir_first = DIR_N;
      dir_final = DIR_NW; // Queen walks all eight
      case (piece[2:0])
         PIECE_ROOK:   dir_final = DIR_W;
         PIECE_BISHOP: dir_first = DIR_NE;
         PIECE_QUEEN:  dir_first = DIR_N;
         default:      is_slider = 1'b0;
      endcase
   end

   // Position is held for the whole scan
   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && board_valid)
      begin
         board_q  <= board;
         white_q  <= white_to_move;
         castle_q <= castle_mask;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= ST_IDLE;
         sq       <= '0;
         dir      <= '0;
         dir_last <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (board_valid)
                  state <= ST_LATCH;
            ST_LATCH:
            begin
               sq    <= '0;
               state <= ST_SQUARE;
            end
            ST_SQUARE:
               if (own_piece && is_slider)
               begin
                  dir      <= dir_first;
                  dir_last <= dir_final;
                  state    <= ST_RAY;
               end
               else if (sq == LAST_SQUARE)
                  state <= ST_DONE;
               else
                  sq <= sq + 6'd1; // Skip in one cycle
            ST_RAY:
               state <= ST_WAIT_RAY;
            ST_WAIT_RAY:
               if (ray_done)
               begin
                  if (dir != dir_last)
                  begin
                     dir   <= dir + 3'd1;
                     state <= ST_RAY;
                  end
                  else if (sq == LAST_SQUARE)
                     state <= ST_DONE;
                  else
                  begin
                     sq    <= sq + 6'd1;
                     state <= ST_SQUARE;
                  end
               end
            ST_DONE:
               if (clear_moves)
                  state <= ST_IDLE;
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   assign start       = (state == ST_LATCH);
   assign ray_start   = (state == ST_RAY);
   assign from_sq     = sq;
   assign ray_dir     = dir;
   assign moves_ready = (state == ST_DONE);

endmodule

//--- logic/vchess_pkg.sv
package vchess_pkg;

   // Square encoding, black flag on top of a 3-bit type
   localparam int PIECE_BITS = 4;
   localparam int BLACK_BIT  = 3;

   localparam int SQUARES       = 64;
   localparam int BOARD_BITS    = SQUARES * PIECE_BITS;
   localparam int MAX_POSITIONS = 128;

   typedef logic [BOARD_BITS-1:0] board_t;
   typedef logic [PIECE_BITS-1:0] piece_t;
   typedef logic [5:0]            square_t; // row*8 + col, row 0 is rank 1
   typedef logic [2:0]            dir_t;
   typedef logic [6:0]            move_index_t;
   typedef logic [7:0]            move_count_t; // Holds 0 to 128
   typedef logic [3:0]            castle_t;
   typedef logic [3:0]            ep_t;

   localparam piece_t EMPTY_POSN = 4'd0;

   // Piece type codes in bits 2..0
   localparam logic [2:0] PIECE_PAWN   = 3'd1;
   localparam logic [2:0] PIECE_KNIGHT = 3'd2;
   localparam logic [2:0] PIECE_BISHOP = 3'd3;
   localparam logic [2:0] PIECE_ROOK   = 3'd4;
   localparam logic [2:0] PIECE_QUEEN  = 3'd5;
   localparam logic [2:0] PIECE_KING   = 3'd6;

   // Castle mask bits
   localparam int CASTLE_WK = 0;
   localparam int CASTLE_WQ = 1;
   localparam int CASTLE_BK = 2;
   localparam int CASTLE_BQ = 3;

   // Rook home squares tied to each castle bit
   localparam square_t ROOK_HOME_WK = 6'd7;
   localparam square_t ROOK_HOME_WQ = 6'd0;
   localparam square_t ROOK_HOME_BK = 6'd63;
   localparam square_t ROOK_HOME_BQ = 6'd56;

   localparam ep_t EP_NONE = 4'hf;

   // Ray directions, rook set first then bishop set
   localparam dir_t DIR_N  = 3'd0; // row+1
   localparam dir_t DIR_E  = 3'd1; // col+1
   localparam dir_t DIR_S  = 3'd2;
   localparam dir_t DIR_W  = 3'd3;
   localparam dir_t DIR_NE = 3'd4;
   localparam dir_t DIR_SE = 3'd5;
   localparam dir_t DIR_SW = 3'd6;
   localparam dir_t DIR_NW = 3'd7;

   localparam square_t LAST_SQUARE = 6'd63;

   // One move RAM word: {ep, castle, side, board}
   localparam int RAM_BITS = BOARD_BITS + 4 + 4 + 1;

endpackage

//--- move_gen.f
logic/vchess_pkg.sv
logic/square_scan.sv
logic/ray_walker.sv
logic/move_store.sv
logic/move_gen.sv
testbench/move_gen_assert.sv
testbench/move_gen_tb.sv

//--- testbench/move_gen_assert.sv
`timescale 1ns/1ps

module move_gen_assert
(
   input logic clk,
   input logic reset,
   input logic ray_start,
   input logic ray_done,
   input logic move_valid,
   input logic moves_ready
);

   logic ray_open; // Ray issued and not yet done

   always_ff @(posedge clk)
   begin
      if (reset)
         ray_open <= 1'b0;
      else if (ray_start)
         ray_open <= 1'b1;
      else if (ray_done)
         ray_open <= 1'b0;
   end

   no_ray_overlap: assert property (@(posedge clk) disable iff (reset)
      ray_start |-> !ray_open)
      else $error("ray_start issued while a ray is outstanding");

   move_inside_ray: assert property (@(posedge clk) disable iff (reset)
      move_valid |-> (ray_open && !ray_done))
      else $error("move_valid outside a ray");

   ready_low_after_reset: assert property (@(posedge clk)
      reset |=> !moves_ready)
      else $error("moves_ready high in the cycle after reset");

endmodule

bind move_gen move_gen_assert assert0
(
   .clk         (clk),
   .reset       (reset),
   .ray_start   (ray_start),
   .ray_done    (ray_done),
   .move_valid  (move_valid),
   .moves_ready (moves_ready)
);

//--- testbench/move_gen_tb.sv
`timescale 1ns/1ps

module move_gen_tb;
   import vchess_pkg::*;

   localparam int WAIT_LIMIT = 20000;

   logic        clk;
   logic        reset;
   logic        board_valid;
   board_t      board;
   logic        white_to_move;
   castle_t     castle_mask;
   ep_t         en_passant_col;
   move_index_t move_index;
   logic        clear_moves;
   logic        moves_ready;
   move_count_t move_count;
   logic        overflow;
   board_t      board_out;
   logic        white_to_move_out;
   castle_t     castle_mask_out;
   ep_t         en_passant_col_out;

   logic [31:0] rng;
   int          errors;
   int          checks;
   logic        timed_out;

   // Expected successors in generation order
   board_t      exp_board[$];
   castle_t     exp_castle[$];
   logic        exp_side;

   // Row and column steps for N E S W NE SE SW NW
   int dr_tab[8] = '{1, 0, -1, 0, 1, -1, -1, 1};
   int dc_tab[8] = '{0, 1, 0, -1, 1, 1, -1, -1};

   move_gen dut0
   (
      .clk                (clk),
      .reset              (reset),
      .board_valid        (board_valid),
      .board              (board),
      .white_to_move      (white_to_move),
      .castle_mask        (castle_mask),
      .en_passant_col     (en_passant_col),
      .move_index         (move_index),
      .clear_moves        (clear_moves),
      .moves_ready        (moves_ready),
      .move_count         (move_count),
      .overflow           (overflow),
      .board_out          (board_out),
      .white_to_move_out  (white_to_move_out),
      .castle_mask_out    (castle_mask_out),
      .en_passant_col_out (en_passant_col_out)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   task automatic check_hex(input string name, input logic [255:0] got,
                            input logic [255:0] want);
      checks++;
      assert (got === want)
      else
      begin
         $display("Fail %s: got %0h, expected %0h", name, got, want);
         errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond)
      else
      begin
         $display("Error: %s", what);
         errors++;
      end
   endtask

   // One successor by the move rule
   task automatic add_move(input board_t b, input castle_t cm, input int from, input int to);
      board_t  nb;
      castle_t nc;
      nb = b;
      nb[from*4 +: 4] = 4'h0;
      nb[to*4 +: 4]   = b[from*4 +: 4];
      nc = cm;
      if (from == 7 || to == 7)
         nc[0] = 1'b0;
      if (from == 0 || to == 0)
         nc[1] = 1'b0;
      if (from == 63 || to == 63)
         nc[2] = 1'b0;
      if (from == 56 || to == 56)
         nc[3] = 1'b0; // Black queen side rook home
      exp_board.push_back(nb);
      exp_castle.push_back(nc);
   endtask

   task automatic build_model(input board_t b, input logic side, input castle_t cm);
      int         sq;
      int         d;
      int         d_lo;
      int         d_hi;
      int         r;
      int         c;
      logic [3:0] p;
      logic [3:0] t;
      logic       own_black;
      logic       blocked;
      exp_board.delete();
      exp_castle.delete();
      exp_side  = ~side;
      own_black = ~side;
      for (sq = 0; sq < 64; sq++)
      begin
         p    = b[sq*4 +: 4];
         d_lo = 0;
         d_hi = -1; // No rays unless an own slider
         if (p != 4'h0 && p[3] == own_black)
         begin
            if (p[2:0] == 3'd4)
               d_hi = 3;
            else if (p[2:0] == 3'd3)
            begin
               d_lo = 4;
               d_hi = 7;
            end
            else if (p[2:0] == 3'd5)
               d_hi = 7;
         end
         for (d = d_lo; d <= d_hi; d++)
         begin
            r       = sq / 8;
            c       = sq % 8;
            blocked = 1'b0;
            while (!blocked)
            begin
               r += dr_tab[d];
               c += dc_tab[d];
               if (r < 0 || r > 7 || c < 0 || c > 7)
                  blocked = 1'b1;
               else
               begin
                  t = b[(r*8 + c)*4 +: 4];
                  if (t != 4'h0 && t[3] == own_black)
                     blocked = 1'b1;
                  else
                  begin
                     add_move(b, cm, sq, r*8 + c);
                     blocked = (t != 4'h0); // Capture ends the ray
                  end
               end
            end
         end
      end
   endtask

   task automatic random_board(input int density, output board_t b);
      int          sq;
      logic [31:0] r;
      b = '0;
      for (sq = 0; sq < 64; sq++)
      begin
         r = next_rand();
         if (int'(r % 32'd100) < density)
            b[sq*4 +: 4] = {r[20], 3'(r[15:8] % 8'd6 + 8'd1)};
      end
   endtask

   // Eight non-attacking white queens
   task automatic queen_board(output board_t b);
      int i;
      int qsq[8] = '{0, 12, 23, 29, 34, 46, 49, 59};
      b = '0;
      for (i = 0; i < 8; i++)
         b[qsq[i]*4 +: 4] = 4'h5;
   endtask

   task automatic apply_position(input board_t b, input logic side, input castle_t cm);
      @(negedge clk);
      board          = b;
      white_to_move  = side;
      castle_mask    = cm;
      en_passant_col = ep_t'(next_rand());
      board_valid    = 1'b1;
      @(negedge clk);
      board_valid    = 1'b0;
   endtask

   task automatic wait_ready(output logic ok);
      int n;
      ok = 1'b0;
      for (n = 0; n < WAIT_LIMIT && !ok; n++)
      begin
         @(negedge clk);
         ok = moves_ready;
      end
      check_true(ok, "moves_ready did not rise before the timeout");
      if (!ok)
         timed_out = 1'b1;
   endtask

   task automatic check_results(input logic do_reads);
      int n;
      int i;
      n = exp_board.size();
      if (n > 128)
         n = 128;
      check_hex("move_count", 256'(move_count), 256'(n));
      check_hex("overflow", 256'(overflow), 256'(exp_board.size() > 128));
      for (i = 0; do_reads && i < n; i++)
      begin
         @(negedge clk);
         move_index = move_index_t'(i);
         @(negedge clk); // Registered read
         check_hex($sformatf("board_out[%0d]", i), board_out, exp_board[i]);
         check_hex($sformatf("white_to_move_out[%0d]", i), 256'(white_to_move_out),
                   256'(exp_side));
         check_hex($sformatf("castle_mask_out[%0d]", i), 256'(castle_mask_out),
                   256'(exp_castle[i]));
         check_hex($sformatf("en_passant_col_out[%0d]", i), 256'(en_passant_col_out),
                   256'(4'hf));
      end
   endtask

   task automatic run_position(input board_t b, input logic side, input castle_t cm,
                               input logic do_reads);
      logic ok;
      build_model(b, side, cm);
      apply_position(b, side, cm);
      wait_ready(ok);
      if (ok)
         check_results(do_reads);
   endtask

   task automatic clear_block();
      @(negedge clk);
      clear_moves = 1'b1;
      @(negedge clk);
      clear_moves = 1'b0;
      check_hex("moves_ready", 256'(moves_ready), 256'(0));
   endtask

   task automatic random_runs(input string name, input int runs, input int density,
                              input logic do_reads, input logic corners);
      int          k;
      int          err0;
      board_t      b;
      logic [31:0] r;
      err0 = errors;
      for (k = 0; k < runs && !timed_out; k++)
      begin
         random_board(density, b);
         r = next_rand();
         if (corners)
         begin
            // Own rooks on the white homes, opponent rooks on the black ones
            b[0*4 +: 4]  = {~r[0], 3'd4};
            b[7*4 +: 4]  = {~r[0], 3'd4};
            b[56*4 +: 4] = {r[0], 3'd4};
            b[63*4 +: 4] = {r[0], 3'd4};
         end
         run_position(b, r[0], r[4:1], do_reads);
         clear_block();
      end
      $display("Test %s: %0d errors", name, errors - err0);
   endtask

   task automatic sequencing_test();
      int          err0;
      board_t      b;
      board_t      other;
      logic [31:0] r;
      err0 = errors;
      random_board(30, b);
      r = next_rand();
      run_position(b, r[0], r[4:1], 1'b1);
      random_board(30, other);
      @(negedge clk);
      board       = other;
      board_valid = 1'b1; // Must be ignored in the done state
      @(negedge clk);
      board_valid = 1'b0;
      repeat (3) @(negedge clk);
      check_hex("moves_ready", 256'(moves_ready), 256'(1));
      check_results(1'b1);
      clear_block();
      random_board(30, b);
      r = next_rand();
      run_position(b, r[0], r[4:1], 1'b1);
      clear_block();
      $display("Test sequencing: %0d errors", errors - err0);
   endtask

   task automatic overflow_test();
      int          err0;
      board_t      b;
      logic [31:0] r;
      err0 = errors;
      queen_board(b);
      r = next_rand();
      run_position(b, 1'b1, r[3:0], 1'b1);
      check_true(exp_board.size() > 128, "overflow board gives no more than 128 moves");
      clear_block();
      $display("Test overflow: %0d errors", errors - err0);
   endtask

   task automatic reset_test();
      int          err0;
      int          n;
      board_t      b;
      logic [31:0] r;
      err0 = errors;
      queen_board(b);
      r = next_rand();
      apply_position(b, 1'b1, r[3:0]);
      // Overflow comes while the last queens are still unscanned
      for (n = 0; n < WAIT_LIMIT && !overflow; n++)
         @(negedge clk);
      check_true(overflow, "overflow did not rise before the timeout");
      check_hex("moves_ready", 256'(moves_ready), 256'(0));
      reset = 1'b1;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      check_hex("moves_ready", 256'(moves_ready), 256'(0));
      check_hex("move_count", 256'(move_count), 256'(0));
      check_hex("overflow", 256'(overflow), 256'(0));
      @(negedge clk);
      check_hex("moves_ready", 256'(moves_ready), 256'(0));
      random_board(30, b);
      r = next_rand();
      run_position(b, r[0], r[4:1], 1'b1);
      reset = 1'b1; // Out of the done state
      @(negedge clk);
      reset = 1'b0;
      check_hex("moves_ready", 256'(moves_ready), 256'(0));
      $display("Test reset: %0d errors", errors - err0);
   endtask

   initial
   begin
      clk            = 1'b0;
      reset          = 1'b1;
      board_valid    = 1'b0;
      board          = '0;
      white_to_move  = 1'b1;
      castle_mask    = '0;
      en_passant_col = 4'hf;
      move_index     = '0;
      clear_moves    = 1'b0;
      rng            = 32'd19034;
      errors         = 0;
      checks         = 0;
      timed_out      = 1'b0;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      random_runs("count", 40, 30, 1'b0, 1'b0);
      if (!timed_out)
         random_runs("positions", 12, 30, 1'b1, 1'b0);
      if (!timed_out)
         random_runs("castle", 10, 20, 1'b1, 1'b1);
      if (!timed_out)
         sequencing_test();
      if (!timed_out)
         overflow_test();
      if (!timed_out)
         reset_test();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
